//--- list.f
+incdir+tb
logic/cpu_isa_pkg.sv
logic/cpu_pipe_pkg.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/cpu_core.sv
tb/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_cpu_core -f list.f -o tb_cpu_core > /dev/null &&
./obj_dir/tb_cpu_core | tee /dev/stderr | grep -q -x -F "=== PASS ===" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}

//--- tb/tb_program.svh
task automatic load_program();
    word_t lb_val;
    word_t lbu_val;
    mem_41        = dpat(8'h41);
    mem_41[15:8]  = 8'hff;              // lane 1 from the sb
    lb_val        = {{24{mem_41[23]}}, mem_41[23:16]};
    lbu_val       = {24'b0, mem_41[31:24]};
    mem_42        = lb_val + lbu_val;
    // alu set, each result feeding the next few
    step(0, enc_i(op_lui, 0, 1, 16'h1234), 1, 32'h1234_0000, 0);
    step(1, enc_i(op_ori, 1, 1, 16'h5678), 1, 32'h1234_5678, 1);
    step(2, enc_i(op_addiu, 0, 2, -1), 2, 32'hffff_ffff, 1);
    step(3, enc_r(fn_addu, 1, 2, 3, 0), 3, 32'h1234_5677, 1);
    step(4, enc_r(fn_subu, 1, 3, 4, 0), 4, 32'h0000_0001, 1);
    step(5, enc_r(fn_and, 1, 2, 5, 0), 5, 32'h1234_5678, 1);
    step(6, enc_r(fn_or, 4, 1, 6, 0), 6, 32'h1234_5679, 1);
    step(7, enc_r(fn_xor, 1, 3, 7, 0), 7, 32'h0000_000f, 1);
    step(8, enc_r(fn_nor, 0, 4, 8, 0), 8, 32'hffff_fffe, 1);
    step(9, enc_r(fn_slt, 2, 4, 9, 0), 9, 32'h0000_0001, 1);
    step(10, enc_r(fn_sltu, 2, 4, 10, 0), 10, 32'h0000_0000, 1);
    step(11, enc_r(fn_sll, 0, 1, 11, 4), 11, 32'h2345_6780, 1);
    step(12, enc_r(fn_srl, 0, 2, 12, 28), 12, 32'h0000_000f, 1);
    step(13, enc_r(fn_sra, 0, 8, 13, 1), 13, 32'hffff_ffff, 1);
    step(14, enc_i(op_slti, 2, 14, 0), 14, 32'h0000_0001, 1);
    step(15, enc_i(op_sltiu, 4, 15, 16'hffff), 15, 32'h0000_0001, 1);
    step(16, enc_i(op_andi, 2, 16, 16'h8001), 16, 32'h0000_8001, 1);
    step(17, enc_i(op_xori, 1, 17, 16'hffff), 17, 32'h1234_a987, 1);
    step(18, enc_i(op_addiu, 0, 20, 16'h0100), 20, 32'h0000_0100, 1);
    // stores then loads through base r20
    put(19, enc_i(op_sw, 20, 1, 0));
    put(20, enc_i(op_sb, 20, 2, 5));
    step(21, enc_i(op_lw, 20, 21, 0), 21, 32'h1234_5678, 2);
    step(22, enc_i(op_lw, 20, 22, 4), 22, mem_41, 2);
    step(23, enc_i(op_lb, 20, 23, 6), 23, lb_val, 2);
    step(24, enc_i(op_lbu, 20, 24, 7), 24, lbu_val, 2);
    step(25, enc_r(fn_addu, 24, 23, 25, 0), 25, mem_42, 2);
    // branches and jumps, skipped slots never traced
    put(26, enc_i(op_beq, 1, 21, 2));
    step(27, enc_i(op_addiu, 0, 26, 7), 26, 32'h0000_0007, 3);
    put(28, enc_i(op_addiu, 0, 26, 16'h0055));
    put(29, enc_i(op_bne, 1, 21, 2));
    step(30, enc_i(op_addiu, 0, 27, 9), 27, 32'h0000_0009, 3);
    step(31, enc_i(op_addiu, 0, 28, 16'h0011), 28, 32'h0000_0011, 3);
    step(32, enc_j(op_jal, 36), 31, reset_pc + 32'd136, 3);
    step(33, enc_i(op_addiu, 0, 29, 3), 29, 32'h0000_0003, 3);
    put(36, enc_r(fn_jr, 31, 0, 0, 0));
    step(37, enc_i(op_addiu, 0, 3, 16'h0022), 3, 32'h0000_0022, 3);
    put(34, enc_j(op_j, 40));
    step(35, enc_i(op_addiu, 0, 30, 16'h0044), 30, 32'h0000_0044, 3);
    put(38, enc_i(op_addiu, 0, 5, 16'h0077));
    put(39, enc_i(op_addiu, 0, 5, 16'h0078));
    // branch on a register still being loaded
    step(40, enc_i(op_lw, 20, 6, 0), 6, 32'h1234_5678, 4);
    put(41, enc_i(op_bne, 6, 20, 2));
    step(42, enc_i(op_addiu, 0, 7, 1), 7, 32'h0000_0001, 4);
    put(43, enc_i(op_addiu, 0, 7, 2));
    step(44, enc_i(op_lw, 20, 8, 0), 8, 32'h1234_5678, 4);
    put(45, enc_i(op_beq, 8, 20, 2));
    step(46, enc_i(op_addiu, 0, 9, 5), 9, 32'h0000_0005, 4);
    step(47, enc_i(op_addiu, 0, 9, 6), 9, 32'h0000_0006, 4);
    put(48, enc_i(op_sw, 20, 25, 8));
    step(49, enc_i(op_addiu, 0, 10, 16'h003c), 10, 32'h0000_003c, 4);
endtask

//--- tb/tb_cpu_core.sv
module tb_cpu_core;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_isa_pkg::*;

    localparam int imem_words = 64;
    localparam int max_exp    = 64;
    localparam int n_tests    = 6;

    logic     aclk;
    logic     rst_n;
    logic     inst_req;
    word_t    inst_addr;
    word_t    inst_rdata;
    logic     data_req;
    logic     data_wr;
    strobe_t  data_wstrb;
    word_t    data_addr;
    logic [1:0] data_size;
    word_t    data_wdata;
    word_t    data_rdata;
    word_t    debug_wb_pc;
    strobe_t  debug_wb_rf_wen;
    reg_idx_t debug_wb_rf_wnum;
    word_t    debug_wb_rf_wdata;

    word_t    imem [imem_words];
    word_t    dmem [256];
    word_t    exp_pc [max_exp];
    reg_idx_t exp_wnum [max_exp];
    word_t    exp_wdata [max_exp];
    int       exp_test [max_exp];
    logic [1:0] size_q [$];   // access width of each load or store, in program order
    int       n_exp;
    int       n_seen;
    int       test_errs [n_tests];
    int       tests_pass;
    int       tests_fail;
    word_t    mem_41;       // word 0x41 after the sb
    word_t    mem_42;       // word 0x42 after the final sw
    word_t    ia;
    word_t    da;
    word_t    dd;
    logic     dr;
    logic     dw;
    strobe_t  ds;
    logic [1:0] dz;
    string    test_name [n_tests] = '{"reset", "alu and forwarding", "memory",
                                      "control flow", "load then branch", "data port"};

    cpu_core cpu_core_inst (.*);

    function automatic word_t dpat(logic [7:0] i);
        return {i ^ 8'ha5, ~i, i, i ^ 8'h3c};
    endfunction

    function automatic word_t enc_r(funct_t fn, int rs, int rt, int rd, int sh);
        return {op_special, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t enc_j(opcode_t op, int idx);
        word_t tgt;
        tgt = reset_pc + word_t'(4 * idx);
        return {op, tgt[27:2]};
    endfunction

    function automatic word_t imem_read(word_t a);
        word_t off;
        off = a - reset_pc;
        if (off < word_t'(4 * imem_words))
            return imem[off[7:2]];
        return nop_word;    // outside the program
    endfunction

    // word accesses are size 2, byte accesses size 0
    function automatic void note_access(word_t w);
        opcode_t op;
        op = w[31:26];
        if (op == op_lw || op == op_sw)
            size_q.push_back(2'b10);
        else if (op == op_lb || op == op_lbu || op == op_sb)
            size_q.push_back(2'b00);
    endfunction

    task automatic put(int idx, word_t w);
        imem[idx] = w;
        note_access(w);
    endtask

    task automatic step(int idx, word_t w, int wnum, word_t wdata, int test);
        imem[idx]         = w;
        exp_pc[n_exp]     = reset_pc + word_t'(4 * idx);
        exp_wnum[n_exp]   = reg_idx_t'(wnum);
        exp_wdata[n_exp]  = wdata;
        exp_test[n_exp]   = test;
        n_exp++;
        note_access(w);
    endtask

    `include "tb_program.svh"

    task automatic report_test(int t);
        if (test_errs[t] == 0) begin
            tests_pass++;
            $display("test %s: ok", test_name[t]);
        end else begin
            tests_fail++;
            $display("test %s: failed with %0d errors", test_name[t], test_errs[t]);
        end
    endtask

    task automatic check_trace();
        int t;
        t = exp_test[n_seen];
        assert (debug_wb_rf_wen == 4'b1111) else begin
            $display("[ERROR] %0t debug_wb_rf_wen expected f got %h", $time, debug_wb_rf_wen);
            test_errs[t]++;
        end
        assert (debug_wb_pc == exp_pc[n_seen]) else begin
            $display("[ERROR] %0t debug_wb_pc expected %h got %h",
                     $time, exp_pc[n_seen], debug_wb_pc);
            test_errs[t]++;
        end
        assert (debug_wb_rf_wnum == exp_wnum[n_seen]) else begin
            $display("[ERROR] %0t debug_wb_rf_wnum expected %0d got %0d",
                     $time, exp_wnum[n_seen], debug_wb_rf_wnum);
            test_errs[t]++;
        end
        assert (debug_wb_rf_wdata == exp_wdata[n_seen]) else begin
            $display("[ERROR] %0t debug_wb_rf_wdata expected %h got %h",
                     $time, exp_wdata[n_seen], debug_wb_rf_wdata);
            test_errs[t]++;
        end
        n_seen++;
        if (n_seen == n_exp || exp_test[n_seen] != t)
            report_test(t);
    endtask

    task automatic check_word(logic [7:0] idx, word_t expected);
        assert (dmem[idx] == expected) else begin
            $display("[ERROR] %0t dmem[%h] expected %h got %h", $time, idx, expected, dmem[idx]);
            test_errs[5]++;
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // one-cycle memories, values captured before the edge updates
    always @(posedge aclk) begin
        ia = inst_addr;
        dr = data_req;
        dw = data_wr;
        da = data_addr;
        dd = data_wdata;
        ds = data_wstrb;
        dz = data_size;
        #1;
        inst_rdata = imem_read(ia);
        if (dr) begin
            assert (size_q.size() != 0) else begin
                $display("unexpected data request at %0t with no load or store left", $time);
                test_errs[5]++;
            end
            if (size_q.size() != 0) begin
                assert (dz == size_q[0]) else begin
                    $display("[ERROR] %0t data_size expected %b got %b", $time, size_q[0], dz);
                    test_errs[5]++;
                end
                void'(size_q.pop_front());
            end
            for (int b = 0; b < 4; b++)
                if (dw && ds[b])
                    dmem[da[9:2]][8*b +: 8] = dd[8*b +: 8];
            data_rdata = dmem[da[9:2]];
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (rst_n === 1'b1);
        while (cycles < 4 * n_exp + 40) begin
            @(posedge aclk);
            cycles++;
        end
        $display("trace stalled: %0d of %0d write-back entries seen after %0d cycles",
                 n_seen, n_exp, cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        n_exp      = 0;
        n_seen     = 0;
        tests_pass = 0;
        tests_fail = 0;
        for (int t = 0; t < n_tests; t++)
            test_errs[t] = 0;
        for (int i = 0; i < 256; i++)
            dmem[i] = dpat(8'(i));
        for (int i = 0; i < imem_words; i++)
            imem[i] = nop_word;
        load_program();
        repeat (16) begin
            @(negedge aclk);
            assert (data_req == 1'b0 && debug_wb_rf_wen == '0) else begin
                $display("[ERROR] %0t data_req/debug_wb_rf_wen expected 0/0 got %b/%h",
                         $time, data_req, debug_wb_rf_wen);
                test_errs[0]++;
            end
        end
        @(posedge aclk);
        #1 rst_n = 1'b1;
        while (n_seen < n_exp) begin
            @(negedge aclk);
            if (n_seen == 0) begin
                assert (data_req == 1'b0) else begin
                    $display("[ERROR] %0t data_req expected 0 got 1", $time);
                    test_errs[0]++;
                end
            end
            assert (inst_req === 1'b1) else begin
                $display("[ERROR] %0t inst_req expected 1 got %b", $time, inst_req);
                test_errs[exp_test[n_seen]]++;
            end
            if (debug_wb_rf_wen != '0)
                check_trace();
        end
        repeat (4) @(negedge aclk);
        check_word(8'h40, 32'h1234_5678);
        check_word(8'h41, mem_41);
        check_word(8'h42, mem_42);
        assert (size_q.size() == 0) else begin
            $display("data port missed %0d of the program's loads and stores", size_q.size());
            test_errs[5]++;
        end
        report_test(5);
        $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
        if (tests_fail == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- logic/cpu_core.sv
module cpu_core (
    input  logic                  aclk,
    input  logic                  rst_n,
    output logic                  inst_req,
    output cpu_isa_pkg::word_t    inst_addr,
    input  cpu_isa_pkg::word_t    inst_rdata,
    output logic                  data_req,
    output logic                  data_wr,
    output cpu_isa_pkg::strobe_t  data_wstrb,
    output cpu_isa_pkg::word_t    data_addr,
    output logic [1:0]            data_size,
    output cpu_isa_pkg::word_t    data_wdata,
    input  cpu_isa_pkg::word_t    data_rdata,
    output cpu_isa_pkg::word_t    debug_wb_pc,
    output cpu_isa_pkg::strobe_t  debug_wb_rf_wen,
    output cpu_isa_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_isa_pkg::word_t    debug_wb_rf_wdata
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    dec_bundle_t dec;
    logic        dec_valid;
    wb_bundle_t  wb;
    fwd_t        ex_fwd;
    fwd_t        wb_fwd;
    reg_idx_t    rf_raddr_a;
    reg_idx_t    rf_raddr_b;
    word_t       rf_rdata_a;
    word_t       rf_rdata_b;

    decode_stage decode_stage_inst (
        .aclk, .rst_n, .inst_rdata, .ex_fwd, .wb_fwd, .rf_rdata_a, .rf_rdata_b,
        .rf_raddr_a, .rf_raddr_b, .inst_req, .inst_addr, .dec, .dec_valid
    );

    execute_stage execute_stage_inst (
        .aclk, .rst_n, .dec, .dec_valid, .wb_fwd, .ex_fwd, .wb,
        .data_req, .data_wr, .data_wstrb, .data_addr, .data_size, .data_wdata
    );

    result_stage result_stage_inst (
        .aclk, .rst_n, .wb, .data_rdata, .rf_raddr_a, .rf_raddr_b,
        .rf_rdata_a, .rf_rdata_b, .wb_fwd,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

endmodule

//--- logic/result_stage.sv
module result_stage (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  cpu_pipe_pkg::wb_bundle_t wb,
    input  cpu_isa_pkg::word_t       data_rdata,
    input  cpu_isa_pkg::reg_idx_t    rf_raddr_a,
    input  cpu_isa_pkg::reg_idx_t    rf_raddr_b,
    output cpu_isa_pkg::word_t       rf_rdata_a,
    output cpu_isa_pkg::word_t       rf_rdata_b,
    output cpu_pipe_pkg::fwd_t       wb_fwd,
    output cpu_isa_pkg::word_t       debug_wb_pc,
    output cpu_isa_pkg::strobe_t     debug_wb_rf_wen,
    output cpu_isa_pkg::reg_idx_t    debug_wb_rf_wnum,
    output cpu_isa_pkg::word_t       debug_wb_rf_wdata
);
    import cpu_isa_pkg::*;

    logic [7:0] lane;
    word_t      load_val;
    word_t      wdata;

    assign lane     = data_rdata[8*wb.offset +: 8];
    assign load_val = (wb.size == size_word) ? data_rdata
                                             : {{24{wb.load_signed & lane[7]}}, lane};
    assign wdata    = wb.load ? load_val :
                      wb.link ? wb.pc + 32'd8 : wb.result;  // jal links pc+8

    register_file register_file_inst (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .wen     (wb.regwen),
        .waddr   (wb.wreg),
        .wdata   (wdata),
        .raddr_a (rf_raddr_a),
        .raddr_b (rf_raddr_b),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b)
    );

    assign wb_fwd.valid   = wb.regwen && wb.wreg != '0;
    assign wb_fwd.wreg    = wb.wreg;
    assign wb_fwd.data    = wdata;
    assign wb_fwd.is_load = wb.load;

    // r0 writes still show up here
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wen   = {4{wb.regwen}};
    assign debug_wb_rf_wnum  = wb.wreg;
    assign debug_wb_rf_wdata = wdata;

endmodule

//--- logic/execute_stage.sv
module execute_stage (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  cpu_pipe_pkg::dec_bundle_t dec,
    input  logic                      dec_valid,
    input  cpu_pipe_pkg::fwd_t        wb_fwd,
    output cpu_pipe_pkg::fwd_t        ex_fwd,
    output cpu_pipe_pkg::wb_bundle_t  wb,
    output logic                      data_req,
    output logic                      data_wr,
    output cpu_isa_pkg::strobe_t      data_wstrb,
    output cpu_isa_pkg::word_t        data_addr,
    output logic [1:0]                data_size,
    output cpu_isa_pkg::word_t        data_wdata
);
    import cpu_isa_pkg::*;

    word_t      a_val;
    word_t      b_val;
    word_t      alu_b;
    word_t      alu_res;
    logic [1:0] offset;

    // the instruction ahead is now in writeback
    assign a_val = (dec.rs_ren && wb_fwd.valid && wb_fwd.wreg == dec.rs) ? wb_fwd.data : dec.a;
    assign b_val = (dec.rt_ren && wb_fwd.valid && wb_fwd.wreg == dec.rt) ? wb_fwd.data : dec.b;
    assign alu_b = dec.imm_sel ? dec.imm : b_val;

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_res = a_val + alu_b;
            alu_sub:  alu_res = a_val - alu_b;
            alu_and:  alu_res = a_val & alu_b;
            alu_or:   alu_res = a_val | alu_b;
            alu_xor:  alu_res = a_val ^ alu_b;
            alu_nor:  alu_res = ~(a_val | alu_b);
            alu_slt:  alu_res = word_t'($signed(a_val) < $signed(alu_b));
            alu_sltu: alu_res = word_t'(a_val < alu_b);
            alu_sll:  alu_res = alu_b << dec.shamt;     // shifts act on rt
            alu_srl:  alu_res = alu_b >> dec.shamt;
            alu_sra:  alu_res = word_t'($signed(alu_b) >>> dec.shamt);
            alu_lui:  alu_res = alu_b;
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        ex_fwd.valid   = dec_valid && dec.regwen && dec.wreg != '0;
        ex_fwd.wreg    = dec.wreg;
        ex_fwd.data    = dec.link ? dec.pc + 32'd8 : alu_res;
        ex_fwd.is_load = dec.load;
    end

    // data port
    assign offset     = alu_res[1:0];
    assign data_addr  = alu_res & phys_mask;
    assign data_req   = dec_valid && (dec.load || dec.store);
    assign data_wr    = dec_valid && dec.store;
    assign data_wstrb = data_wr ? strobe_t'(dec.size << offset) : '0;
    assign data_size  = (dec.size == size_word) ? 2'b10 : 2'b00;
    assign data_wdata = (dec.size == size_word) ? b_val : {4{b_val[7:0]}}; // sb on every lane

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.pc          <= dec.pc;
            wb.result      <= alu_res;
            wb.load        <= dec_valid && dec.load;
            wb.load_signed <= dec.load_signed;
            wb.offset      <= offset;
            wb.size        <= dec.size;
            wb.regwen      <= dec_valid && dec.regwen;
            wb.wreg        <= dec.wreg;
            wb.link        <= dec.link;
        end
    end

endmodule

//--- logic/decode_stage.sv
module decode_stage (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  cpu_isa_pkg::word_t        inst_rdata,
    input  cpu_pipe_pkg::fwd_t        ex_fwd,
    input  cpu_pipe_pkg::fwd_t        wb_fwd,
    input  cpu_isa_pkg::word_t        rf_rdata_a,
    input  cpu_isa_pkg::word_t        rf_rdata_b,
    output cpu_isa_pkg::reg_idx_t     rf_raddr_a,
    output cpu_isa_pkg::reg_idx_t     rf_raddr_b,
    output logic                      inst_req,
    output cpu_isa_pkg::word_t        inst_addr,
    output cpu_pipe_pkg::dec_bundle_t dec,
    output logic                      dec_valid
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    word_t       id_pc;
    logic        id_valid;
    word_t       hold_q;
    logic        hold_valid;
    word_t       inst;
    opcode_t     opcode;
    funct_t      funct;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    word_t       pc_plus4;
    word_t       rs_val;
    word_t       rt_val;
    imm_kind_e   imm_kind;
    dec_bundle_t nxt;
    logic        cmp_op;
    logic        taken;
    word_t       target;
    logic        stall;
    logic        issue;

    // execute first, then writeback, then the file
    function automatic word_t pick(reg_idx_t r, word_t rf_val, fwd_t ex, fwd_t wb);
        if (ex.valid && ex.wreg == r)
            return ex.data;
        if (wb.valid && wb.wreg == r)
            return wb.data;
        return rf_val;
    endfunction

    assign inst_req = 1'b1;
    assign inst     = !id_valid ? nop_word : hold_valid ? hold_q : inst_rdata;
    assign opcode   = inst[31:26];
    assign funct    = inst[5:0];
    assign rs       = inst[25:21];
    assign rt       = inst[20:16];
    assign rd       = inst[15:11];
    assign pc_plus4 = id_pc + 32'd4;

    assign rf_raddr_a = rs;
    assign rf_raddr_b = rt;
    assign rs_val     = pick(rs, rf_rdata_a, ex_fwd, wb_fwd);
    assign rt_val     = pick(rt, rf_rdata_b, ex_fwd, wb_fwd);

    always_comb begin
        nxt        = '0;
        nxt.pc     = id_pc;
        nxt.rs     = rs;
        nxt.rt     = rt;
        nxt.a      = rf_rdata_a;
        nxt.b      = rf_rdata_b;
        nxt.shamt  = inst[10:6];
        nxt.alu_op = alu_add;
        imm_kind   = imm_sign;
        cmp_op     = 1'b0;
        taken      = 1'b0;
        target     = {pc_plus4[31:28], inst[25:0], 2'b00};
        case (opcode)
            op_special: begin
                nxt.regwen = 1'b1;
                nxt.wreg   = rd;
                nxt.rs_ren = 1'b1;
                nxt.rt_ren = 1'b1;
                case (funct)
                    fn_sll:  nxt.alu_op = alu_sll;
                    fn_srl:  nxt.alu_op = alu_srl;
                    fn_sra:  nxt.alu_op = alu_sra;
                    fn_addu: nxt.alu_op = alu_add;
                    fn_subu: nxt.alu_op = alu_sub;
                    fn_and:  nxt.alu_op = alu_and;
                    fn_or:   nxt.alu_op = alu_or;
                    fn_xor:  nxt.alu_op = alu_xor;
                    fn_nor:  nxt.alu_op = alu_nor;
                    fn_slt:  nxt.alu_op = alu_slt;
                    fn_sltu: nxt.alu_op = alu_sltu;
                    fn_jr: begin
                        nxt.regwen = 1'b0;
                        nxt.rt_ren = 1'b0;
                        cmp_op     = 1'b1;
                        taken      = 1'b1;
                        target     = rs_val;
                    end
                    default: nxt = '0;      // unknown funct, nop
                endcase
                if (funct == fn_sll || funct == fn_srl || funct == fn_sra)
                    nxt.rs_ren = 1'b0;
            end
            op_j: taken = 1'b1;
            op_jal: begin
                taken      = 1'b1;
                nxt.regwen = 1'b1;
                nxt.wreg   = ra_reg;
                nxt.link   = 1'b1;
            end
            op_beq, op_bne: begin
                nxt.rs_ren = 1'b1;
                nxt.rt_ren = 1'b1;
                cmp_op     = 1'b1;
                taken      = (rs_val == rt_val) ^ (opcode == op_bne);
                target     = pc_plus4 + {{14{inst[15]}}, inst[15:0], 2'b00};
            end
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                nxt.rs_ren  = (opcode != op_lui);
                nxt.imm_sel = 1'b1;
                nxt.regwen  = 1'b1;
                nxt.wreg    = rt;
                case (opcode)
                    op_slti:  nxt.alu_op = alu_slt;
                    op_sltiu: nxt.alu_op = alu_sltu;
                    op_andi:  nxt.alu_op = alu_and;
                    op_ori:   nxt.alu_op = alu_or;
                    op_xori:  nxt.alu_op = alu_xor;
                    op_lui:   nxt.alu_op = alu_lui;
                    default:  nxt.alu_op = alu_add;
                endcase
                if (opcode == op_andi || opcode == op_ori || opcode == op_xori)
                    imm_kind = imm_zero;
                else if (opcode == op_lui)
                    imm_kind = imm_upper;
            end
            op_lb, op_lbu, op_lw: begin
                nxt.rs_ren      = 1'b1;
                nxt.imm_sel     = 1'b1;
                nxt.load        = 1'b1;
                nxt.load_signed = (opcode == op_lb);
                nxt.size        = (opcode == op_lw) ? size_word : size_byte;
                nxt.regwen      = 1'b1;
                nxt.wreg        = rt;
            end
            op_sb, op_sw: begin
                nxt.rs_ren  = 1'b1;
                nxt.rt_ren  = 1'b1;
                nxt.imm_sel = 1'b1;
                nxt.store   = 1'b1;
                nxt.size    = (opcode == op_sw) ? size_word : size_byte;
            end
            default: ;
        endcase
        case (imm_kind)
            imm_zero:  nxt.imm = {16'b0, inst[15:0]};
            imm_upper: nxt.imm = {inst[15:0], 16'b0};
            default:   nxt.imm = {{16{inst[15]}}, inst[15:0]};
        endcase
    end

    // branch operand still in the data memory
    assign stall = id_valid && cmp_op && ex_fwd.valid && ex_fwd.is_load &&
                   ((nxt.rs_ren && ex_fwd.wreg == rs) || (nxt.rt_ren && ex_fwd.wreg == rt));
    assign issue = id_valid && !stall;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            inst_addr  <= reset_pc;
            id_pc      <= reset_pc;
            id_valid   <= 1'b0;
            hold_valid <= 1'b0;
            dec        <= '0;
            dec_valid  <= 1'b0;
        end else begin
            hold_valid <= stall;
            dec        <= issue ? nxt : '0;     // bubble on interlock
            dec_valid  <= issue;
            if (!stall) begin
                id_valid  <= 1'b1;
                id_pc     <= inst_addr;
                inst_addr <= (issue && taken) ? target : inst_addr + 32'd4;
            end
        end
    end

    always_ff @(posedge aclk) begin
        hold_q <= inst;
    end

endmodule

//--- logic/register_file.sv
module register_file (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  wen,
    input  cpu_isa_pkg::reg_idx_t waddr,
    input  cpu_isa_pkg::word_t    wdata,
    input  cpu_isa_pkg::reg_idx_t raddr_a,
    input  cpu_isa_pkg::reg_idx_t raddr_b,
    output cpu_isa_pkg::word_t    rdata_a,
    output cpu_isa_pkg::word_t    rdata_b
);
    import cpu_isa_pkg::*;

    word_t regs [32];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so decode sees the value being retired
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (wen && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (wen && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

//--- logic/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    typedef enum logic [1:0] {
        imm_zero,
        imm_sign,
        imm_upper   // imm in the high half
    } imm_kind_e;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rs;
        reg_idx_t rt;
        logic     rs_ren;
        logic     rt_ren;
        word_t    a;
        word_t    b;
        logic     imm_sel;      // imm replaces b
        word_t    imm;
        alu_op_e  alu_op;
        logic [4:0] shamt;
        logic     load;
        logic     load_signed;
        logic     store;
        strobe_t  size;
        logic     regwen;
        reg_idx_t wreg;
        logic     link;
    } dec_bundle_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        logic     load;
        logic     load_signed;
        logic [1:0] offset;     // byte within the word
        strobe_t  size;
        logic     regwen;
        reg_idx_t wreg;
        logic     link;
    } wb_bundle_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t wreg;
        word_t    data;
        logic     is_load;      // data not ready yet
    } fwd_t;

endpackage

//--- logic/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int word_w = 32;
    localparam int reg_w  = 5;
    localparam int op_w   = 6;
    localparam int fn_w   = 6;
    localparam int strb_w = 4;

    typedef logic [word_w-1:0] word_t;
    typedef logic [reg_w-1:0]  reg_idx_t;
    typedef logic [op_w-1:0]   opcode_t;
    typedef logic [fn_w-1:0]   funct_t;
    typedef logic [strb_w-1:0] strobe_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    localparam word_t    reset_pc  = 32'hbfc0_0000;
    localparam reg_idx_t ra_reg    = 5'd31;
    localparam word_t    phys_mask = 32'h1fff_ffff; // kseg0/1 fold onto low 512M
    localparam word_t    nop_word  = '0;

    localparam strobe_t size_word = 4'b1111;
    localparam strobe_t size_byte = 4'b0001;

    // major opcodes
    localparam opcode_t op_special = 6'h00;
    localparam opcode_t op_j       = 6'h02;
    localparam opcode_t op_jal     = 6'h03;
    localparam opcode_t op_beq     = 6'h04;
    localparam opcode_t op_bne     = 6'h05;
    localparam opcode_t op_addiu   = 6'h09;
    localparam opcode_t op_slti    = 6'h0a;
    localparam opcode_t op_sltiu   = 6'h0b;
    localparam opcode_t op_andi    = 6'h0c;
    localparam opcode_t op_ori     = 6'h0d;
    localparam opcode_t op_xori    = 6'h0e;
    localparam opcode_t op_lui     = 6'h0f;
    localparam opcode_t op_lb      = 6'h20;
    localparam opcode_t op_lw      = 6'h23;
    localparam opcode_t op_lbu     = 6'h24;
    localparam opcode_t op_sb      = 6'h28;
    localparam opcode_t op_sw      = 6'h2b;

    // special function codes
    localparam funct_t fn_sll  = 6'h00;
    localparam funct_t fn_srl  = 6'h02;
    localparam funct_t fn_sra  = 6'h03;
    localparam funct_t fn_jr   = 6'h08;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_nor  = 6'h27;
    localparam funct_t fn_slt  = 6'h2a;
    localparam funct_t fn_sltu = 6'h2b;

endpackage
